//--- rtl/quant_defs.svh
// Quantizer sizing constants: widths, queue depths, matrix count and level limit
`ifndef QUANT_DEFS_SVH
`define QUANT_DEFS_SVH

// Datapath widths
`define QUANT_COEF_W        16
`define QUANT_WIDE_W        32

// Block and matrix geometry
`define QUANT_NUM_POS       16
`define QUANT_NUM_MATRIX    4
`define QUANT_MTX_W         2

// Flow control
`define QUANT_IN_DEPTH      4
`define QUANT_OUT_DEPTH     4
`define QUANT_SINK_CREDITS  2

// Arithmetic
`define QUANT_MAX_LEVEL     2047
`define QUANT_SHIFT         17

`endif

//--- rtl/quant_pkg.sv
// Shared packed types for the coefficient quantizer datapath
`include "quant_defs.svh"

package quant_pkg;

    typedef logic signed [`QUANT_COEF_W-1:0] quant_coef_t;
    typedef logic [`QUANT_MTX_W-1:0]         quant_mtx_t;

    // Parameters of one position in one matrix
    typedef struct packed {
        logic [`QUANT_COEF_W-1:0] q;
        logic [`QUANT_COEF_W-1:0] iq;
        logic [`QUANT_WIDE_W-1:0] bias;
        logic [`QUANT_WIDE_W-1:0] zthresh;
        logic [`QUANT_COEF_W-1:0] sharpen;
    } quant_pos_param_t;

    typedef struct packed {
        quant_mtx_t                        mtx;
        logic [$clog2(`QUANT_NUM_POS)-1:0] pos;
        quant_pos_param_t                  param;
    } quant_cfg_t;

    // Coefficients are in raster order
    typedef struct packed {
        quant_mtx_t                           mtx;
        quant_coef_t [`QUANT_NUM_POS-1:0]     coef;
    } quant_blk_in_t;

    typedef struct packed {
        quant_coef_t [`QUANT_NUM_POS-1:0]      coef;
        quant_pos_param_t [`QUANT_NUM_POS-1:0] param;
    } quant_exec_req_t;

    typedef struct packed {
        quant_coef_t [`QUANT_NUM_POS-1:0] level;
        quant_coef_t [`QUANT_NUM_POS-1:0] recon;
    } quant_exec_rsp_t;

    // Levels in zigzag order, recon in raster order
    typedef struct packed {
        logic                             nz;
        quant_coef_t [`QUANT_NUM_POS-1:0] level;
        quant_coef_t [`QUANT_NUM_POS-1:0] recon;
    } quant_blk_out_t;

endpackage

//--- rtl/quant_credit_fifo.sv
// Circular-buffer FIFO with a generic payload, sized to match a credit pool
`timescale 1ns/10ps

module quant_credit_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       push_i,
    input  payload_t                   push_data_i,
    input  logic                       pop_i,
    output payload_t                   pop_data_o,
    output logic                       empty_o,
    output logic [$clog2(DEPTH+1)-1:0] free_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Storage
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push_i) - CNT_W'(pop_i);
        end
    end

    assign pop_data_o = mem[rd_ptr];
    assign empty_o    = (count == '0);
    assign free_o     = CNT_W'(DEPTH) - count;

    // Credit discipline upstream must keep the buffer from overflowing
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push_i |-> (count != CNT_W'(DEPTH)));

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop_i |-> (count != '0));

endmodule

//--- rtl/quant_param_table.sv
// Register file of per-position quantizer parameters for every matrix
`timescale 1ns/10ps
`include "quant_defs.svh"

module quant_param_table (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          cfg_we_i,
    input  quant_pkg::quant_cfg_t                         cfg_i,
    input  quant_pkg::quant_mtx_t                         mtx_i,
    output quant_pkg::quant_pos_param_t [`QUANT_NUM_POS-1:0] params_o
);

    // One row of sixteen positions per matrix
    quant_pkg::quant_pos_param_t [`QUANT_NUM_POS-1:0] table_q [`QUANT_NUM_MATRIX];

    // ------------------------------
    // Write port
    // ------------------------------
    // A single position is updated per configuration write;
    // unwritten entries read as zero so an unconfigured matrix quantizes to zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int m = 0; m < `QUANT_NUM_MATRIX; m++) begin
                table_q[m] <= '0;
            end
        end else if (cfg_we_i) begin
            table_q[cfg_i.mtx][cfg_i.pos] <= cfg_i.param;
        end
    end

    // ------------------------------
    // Read port
    // ------------------------------
    // Combinational, decode registers it alongside the block
    assign params_o = table_q[mtx_i];

endmodule

//--- rtl/quant_cmd_decode.sv
// Block decode: pops the input queue, looks up the matrix and issues execute requests
`timescale 1ns/10ps
`include "quant_defs.svh"

module quant_cmd_decode (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  logic                                             fifo_empty_i,
    input  quant_pkg::quant_blk_in_t                         fifo_data_i,
    output logic                                             fifo_pop_o,
    output quant_pkg::quant_mtx_t                            mtx_o,
    input  quant_pkg::quant_pos_param_t [`QUANT_NUM_POS-1:0] params_i,
    input  logic                                             stall_i,
    output logic                                             in_credit_o,
    output logic                                             req_valid_o,
    output quant_pkg::quant_exec_req_t                       req_o
);

    // Pop whenever a block waits and the pipeline can advance
    assign fifo_pop_o = !fifo_empty_i && !stall_i;

    // Each pop frees one queue slot for the sender
    assign in_credit_o = fifo_pop_o;

    // Matrix lookup happens in the same cycle as the pop
    assign mtx_o = fifo_data_i.mtx;

    // ------------------------------
    // Request register
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_valid_o <= 1'b0;
        end else if (!stall_i) begin
            req_valid_o <= fifo_pop_o;
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_pop_o) begin
            req_o.coef  <= fifo_data_i.coef;
            req_o.param <= params_i;
        end
    end

    // Every returned credit belongs to a block that reaches execute
    a_credit_issues_req: assert property (@(posedge clk) disable iff (!rst_n)
        in_credit_o |-> (fifo_pop_o ##1 req_valid_o));

endmodule

//--- rtl/quant_block_exec.sv
// Two-stage quantizer for all sixteen coefficients of a block
`timescale 1ns/10ps
`include "quant_defs.svh"

module quant_block_exec (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req_valid_i,
    input  quant_pkg::quant_exec_req_t  req_i,
    input  logic                        stall_i,
    output logic                        rsp_valid_o,
    output quant_pkg::quant_exec_rsp_t  rsp_o
);

    localparam int CW     = `QUANT_COEF_W;
    localparam int WW     = `QUANT_WIDE_W;
    localparam int MAG_W  = CW + 2;
    localparam int PROD_W = 48;

    logic                       s1_valid;
    wire quant_pkg::quant_exec_rsp_t rsp_d;

    // Valid chain, all stages advance together
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid    <= 1'b0;
            rsp_valid_o <= 1'b0;
        end else if (!stall_i) begin
            s1_valid    <= req_valid_i;
            rsp_valid_o <= s1_valid;
        end
    end

    genvar i;
    generate
        for (i = 0; i < `QUANT_NUM_POS; i++) begin : g_pos
            logic signed [CW-1:0]   coef;
            logic                   sign;
            logic [CW:0]            abs_c;
            logic [MAG_W-1:0]       mag;
            logic [PROD_W-1:0]      scaled;
            logic [PROD_W-1:0]      shifted;
            logic [CW-1:0]          lvl_clamp;
            logic                   pass;
            logic [CW-1:0]          s1_lvl;
            logic                   s1_sign;
            logic                   s1_pass;
            logic [CW-1:0]          s1_q;
            logic signed [CW-1:0]   lvl_signed;
            logic signed [2*CW:0]   recon_full;

            // ------------------------------
            // Stage one: magnitude level
            // ------------------------------
            assign coef  = req_i.coef[i];
            assign sign  = coef[CW-1];
            // 17 bits so that the most negative coefficient keeps its magnitude
            assign abs_c = sign ? (CW+1)'(-{coef[CW-1], coef}) : {1'b0, coef};
            assign mag   = MAG_W'(abs_c) + MAG_W'(req_i.param[i].sharpen);

            assign scaled  = PROD_W'(mag) * PROD_W'(req_i.param[i].iq)
                           + PROD_W'(req_i.param[i].bias);
            assign shifted = scaled >> `QUANT_SHIFT;

            assign lvl_clamp = (shifted > PROD_W'(`QUANT_MAX_LEVEL)) ?
                               CW'(`QUANT_MAX_LEVEL) : shifted[CW-1:0];
            assign pass      = WW'(mag) > req_i.param[i].zthresh;

            always_ff @(posedge clk) begin
                if (!stall_i && req_valid_i) begin
                    s1_lvl  <= lvl_clamp;
                    s1_sign <= sign;
                    s1_pass <= pass;
                    s1_q    <= req_i.param[i].q;
                end
            end

            // ------------------------------
            // Stage two: sign, threshold, recon
            // ------------------------------
            assign lvl_signed = s1_sign ? -$signed(s1_lvl) : $signed(s1_lvl);
            assign recon_full = lvl_signed * $signed({1'b0, s1_q});

            assign rsp_d.level[i] = s1_pass ? lvl_signed : '0;
            assign rsp_d.recon[i] = s1_pass ? recon_full[CW-1:0] : '0;
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (!stall_i && s1_valid) begin
            rsp_o <= rsp_d;
        end
    end

    // A held block must not change until result takes it
    a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (stall_i && rsp_valid_o) |=> (rsp_valid_o && $stable(rsp_o)));

endmodule

//--- rtl/quant_result_pack.sv
// Result stage: zigzag reorder, non-zero flag, output queue and credit counter
`timescale 1ns/10ps
`include "quant_defs.svh"

module quant_result_pack (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       rsp_valid_i,
    input  quant_pkg::quant_exec_rsp_t rsp_i,
    input  logic [1:0]                 inflight_i,
    output logic                       stall_o,
    input  logic                       out_credit_i,
    output logic                       out_valid_o,
    output quant_pkg::quant_blk_out_t  out_blk_o
);

    localparam int FREE_W = $clog2(`QUANT_OUT_DEPTH + 1);
    localparam int CRD_W  = $clog2(`QUANT_SINK_CREDITS + 1);

    // Raster position for each zigzag slot
    localparam int ZIGZAG [`QUANT_NUM_POS] =
        '{0, 1, 4, 8, 5, 2, 3, 6, 9, 12, 13, 10, 7, 11, 14, 15};

    quant_pkg::quant_blk_out_t blk_d;
    quant_pkg::quant_blk_out_t head;
    logic                      push;
    logic                      pop;
    logic                      q_empty;
    logic [FREE_W-1:0]         q_free;
    logic [CRD_W-1:0]          credit_cnt;

    // ------------------------------
    // Packing
    // ------------------------------
    always_comb begin
        blk_d.nz    = 1'b0;
        blk_d.recon = rsp_i.recon;
        for (int k = 0; k < `QUANT_NUM_POS; k++) begin
            blk_d.level[k] = rsp_i.level[ZIGZAG[k]];
            blk_d.nz       = blk_d.nz | (rsp_i.level[k] != '0);
        end
    end

    // Hold execute while the queue could not absorb what is upstream
    assign stall_o = (q_free <= FREE_W'(inflight_i));
    assign push    = rsp_valid_i && !stall_o;
    assign pop     = !q_empty && (credit_cnt != '0);

    quant_credit_fifo #(
        .payload_t   (quant_pkg::quant_blk_out_t),
        .DEPTH       (`QUANT_OUT_DEPTH)
    ) u_out_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (push),
        .push_data_i (blk_d),
        .pop_i       (pop),
        .pop_data_o  (head),
        .empty_o     (q_empty),
        .free_o      (q_free)
    );

    // ------------------------------
    // Output credits
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt  <= CRD_W'(`QUANT_SINK_CREDITS);
            out_valid_o <= 1'b0;
        end else begin
            credit_cnt  <= credit_cnt - CRD_W'(pop) + CRD_W'(out_credit_i);
            out_valid_o <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            out_blk_o <= head;
        end
    end

    // Sink never returns more credits than blocks it was sent
    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credit_cnt <= CRD_W'(`QUANT_SINK_CREDITS));

endmodule

//--- rtl/quant_top.sv
// Coefficient quantizer top: input queue, parameter table, decode, execute and result
`timescale 1ns/10ps
`include "quant_defs.svh"

module quant_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cfg_we_i,
    input  quant_pkg::quant_cfg_t      cfg_i,
    input  logic                       in_valid_i,
    input  quant_pkg::quant_blk_in_t   in_blk_i,
    output logic                       in_credit_o,
    output logic                       out_valid_o,
    output quant_pkg::quant_blk_out_t  out_blk_o,
    input  logic                       out_credit_i
);

    quant_pkg::quant_blk_in_t                         fifo_data;
    logic                                             fifo_empty;
    logic                                             fifo_pop;
    quant_pkg::quant_mtx_t                            mtx;
    quant_pkg::quant_pos_param_t [`QUANT_NUM_POS-1:0] params;
    logic                                             stall;
    logic                                             req_valid;
    quant_pkg::quant_exec_req_t                       req;
    logic                                             rsp_valid;
    quant_pkg::quant_exec_rsp_t                       rsp;

    // Input queue, sized to the sender's credit pool
    quant_credit_fifo #(
        .payload_t   (quant_pkg::quant_blk_in_t),
        .DEPTH       (`QUANT_IN_DEPTH)
    ) u_in_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (in_valid_i),
        .push_data_i (in_blk_i),
        .pop_i       (fifo_pop),
        .pop_data_o  (fifo_data),
        .empty_o     (fifo_empty),
        .free_o      ()
    );

    quant_param_table u_table (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg_we_i (cfg_we_i),
        .cfg_i    (cfg_i),
        .mtx_i    (mtx),
        .params_o (params)
    );

    quant_cmd_decode u_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .fifo_empty_i (fifo_empty),
        .fifo_data_i  (fifo_data),
        .fifo_pop_o   (fifo_pop),
        .mtx_o        (mtx),
        .params_i     (params),
        .stall_i      (stall),
        .in_credit_o  (in_credit_o),
        .req_valid_o  (req_valid),
        .req_o        (req)
    );

    quant_block_exec u_exec (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid_i (req_valid),
        .req_i       (req),
        .stall_i     (stall),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp)
    );

    // Blocks held in decode and at the execute output
    quant_result_pack u_result (
        .clk          (clk),
        .rst_n        (rst_n),
        .rsp_valid_i  (rsp_valid),
        .rsp_i        (rsp),
        .inflight_i   ({1'b0, req_valid} + {1'b0, rsp_valid}),
        .stall_o      (stall),
        .out_credit_i (out_credit_i),
        .out_valid_o  (out_valid_o),
        .out_blk_o    (out_blk_o)
    );

endmodule

//--- verif/quant_tb.sv
// Quantizer testbench: file-driven blocks, matrix selection, back-pressure and random stream
`timescale 1ns/10ps
`include "quant_defs.svh"

module quant_tb;

    localparam int TIMEOUT = 2000;
    localparam int SCAN [16] = '{0, 1, 4, 8, 5, 2, 3, 6, 9, 12, 13, 10, 7, 11, 14, 15};

    logic                        clk;
    logic                        rst_n;
    logic                        cfg_we_i;
    quant_pkg::quant_cfg_t       cfg_i;
    logic                        in_valid_i;
    quant_pkg::quant_blk_in_t    in_blk_i;
    logic                        in_credit_o;
    logic                        out_valid_o;
    quant_pkg::quant_blk_out_t   out_blk_o;
    logic                        out_credit_i;

    quant_pkg::quant_pos_param_t prm [4][16];
    quant_pkg::quant_blk_in_t    send_q [$];
    quant_pkg::quant_blk_out_t   exp_q [$];
    quant_pkg::quant_blk_out_t   exp_head;
    logic [31:0]                 seed;
    int                          errors;
    int                          tests_run;
    int                          tests_bad;
    int                          send_credits;
    int                          sent_total;
    int                          in_pulses;
    int                          recv_total;
    int                          returned;
    int                          pending;
    bit                          hold_credits;
    bit                          slow_sink;

    quant_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic bit coin_flip();
        logic [31:0] r;
        r = lcg_next();
        return r[16];
    endfunction

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic quant_pkg::quant_blk_out_t model_block(quant_pkg::quant_blk_in_t blk);
        quant_pkg::quant_blk_out_t   r;
        quant_pkg::quant_pos_param_t p;
        quant_pkg::quant_coef_t      lv [16];
        longint                      c;
        longint                      mag;
        longint                      lvl;
        r = '0;
        for (int i = 0; i < 16; i++) begin
            p   = prm[blk.mtx][i];
            c   = longint'($signed(blk.coef[i]));
            mag = ((c < 0) ? -c : c) + longint'(p.sharpen);
            lvl = (mag * longint'(p.iq) + longint'(p.bias)) >>> `QUANT_SHIFT;
            if (lvl > `QUANT_MAX_LEVEL) lvl = `QUANT_MAX_LEVEL;
            // At or below the threshold both outputs are zero
            if (mag <= longint'(p.zthresh)) lvl = 0;
            if (c < 0) lvl = -lvl;
            lv[i]      = 16'(lvl);
            r.recon[i] = 16'(lvl * longint'(p.q));
            r.nz       = r.nz | (lvl != 0);
        end
        for (int k = 0; k < 16; k++) r.level[k] = lv[SCAN[k]];
        return r;
    endfunction

    function automatic quant_pkg::quant_blk_in_t random_block();
        quant_pkg::quant_blk_in_t b;
        logic [31:0]              r;
        b.mtx = 2'(lcg_next() >> 30);
        for (int i = 0; i < 16; i++) begin
            r = lcg_next();
            case (r[31:30])
                2'd0: b.coef[i] = '0;
                2'd1: b.coef[i] = 16'($signed(r[7:0]));
                2'd2: b.coef[i] = 16'($signed(r[19:8]));
                default: b.coef[i] = r[15:0];
            endcase
        end
        return b;
    endfunction

    task automatic end_run();
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    task automatic timed_out(string what);
        $display("Timeout while %s", what);
        errors++;
        end_run();
    endtask

    task automatic write_cfg(int m, int p, quant_pkg::quant_pos_param_t param);
        @(negedge clk);
        cfg_we_i    = 1'b1;
        cfg_i.mtx   = 2'(m);
        cfg_i.pos   = 4'(p);
        cfg_i.param = param;
        prm[m][p]   = param;
        @(negedge clk);
        cfg_we_i = 1'b0;
    endtask

    task automatic add_block(quant_pkg::quant_blk_in_t b, quant_pkg::quant_blk_out_t e);
        send_q.push_back(b);
        exp_q.push_back(e);
    endtask

    // ------------------------------
    // Stimulus file
    // ------------------------------
    task automatic load_file();
        int                          fd;
        int                          v [17];
        string                       line;
        byte                         kind;
        quant_pkg::quant_blk_in_t    blk;
        quant_pkg::quant_blk_out_t   e;
        quant_pkg::quant_pos_param_t p;
        fd = $fopen("verif/quant_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file verif/quant_tests.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                kind = line.getc(0);
                if (kind == "M" || kind == "C") begin
                    if (kind == "M")
                        void'($sscanf(line, "M %h %h %h %h %h %h",
                                      v[0], v[2], v[3], v[4], v[5], v[6]));
                    else
                        void'($sscanf(line, "C %h %h %h %h %h %h %h",
                                      v[0], v[1], v[2], v[3], v[4], v[5], v[6]));
                    p = {16'(v[2]), 16'(v[3]), 32'(v[4]), 32'(v[5]), 16'(v[6])};
                    for (int i = 0; i < 16; i++) begin
                        if (kind == "M" || i == v[1]) write_cfg(v[0], i, p);
                    end
                end else if (kind == "B" || kind == "E") begin
                    void'($sscanf(line.substr(2, line.len() - 1),
                                  "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                  v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8],
                                  v[9], v[10], v[11], v[12], v[13], v[14], v[15], v[16]));
                    if (kind == "B") begin
                        blk.mtx = 2'(v[0]);
                        for (int i = 0; i < 16; i++) blk.coef[i] = 16'(v[i + 1]);
                    end else begin
                        // Recon comes from the model, levels and flag from the file
                        e    = model_block(blk);
                        e.nz = v[0][0];
                        for (int i = 0; i < 16; i++) e.level[i] = 16'(v[i + 1]);
                        add_block(blk, e);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ------------------------------
    // Sender, sink and test runner
    // ------------------------------
    task automatic send_blocks();
        int idle;
        idle = 0;
        while (send_q.size() > 0) begin
            @(negedge clk);
            if (send_credits > 0) begin
                in_valid_i = 1'b1;
                in_blk_i   = send_q.pop_front();
                send_credits--;
                sent_total++;
                idle = 0;
            end else begin
                in_valid_i = 1'b0;
                idle++;
                if (idle > TIMEOUT) timed_out("the sender waited for input credits");
            end
        end
        @(negedge clk);
        in_valid_i = 1'b0;
    endtask

    task automatic wait_received(int target, string what);
        int cycles;
        cycles = 0;
        while (recv_total < target) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) timed_out(what);
        end
    endtask

    task automatic run_test(string name);
        int err0;
        int n;
        int base;
        err0 = errors;
        n    = send_q.size();
        base = recv_total;
        fork
            send_blocks();
        join_none
        if (hold_credits) begin
            wait_received(base + `QUANT_SINK_CREDITS, "waiting for the first granted blocks");
            repeat (40) @(negedge clk);
            hold_credits = 1'b0;
        end
        wait_received(base + n, {"waiting for the outputs of ", name});
        wait fork;
        if (in_pulses != sent_total) begin
            $display("Error at %0t: %0d input credits for %0d blocks", $time, in_pulses,
                     sent_total);
            errors++;
        end
        tests_run++;
        if (errors != err0) tests_bad++;
        $display("Test %s: %0d blocks, %0d errors", name, n, errors - err0);
    endtask

    // A credit may only return for a block already sent
    always @(posedge clk) begin
        if (rst_n && in_credit_o) begin
            send_credits++;
            in_pulses++;
            if (in_pulses > sent_total) begin
                $display("Error at %0t: input credit %0d returned with %0d blocks sent",
                         $time, in_pulses, sent_total);
                errors++;
            end
        end
    end

    // Output check and credit return
    always @(negedge clk) begin
        out_credit_i = 1'b0;
        if (rst_n && out_valid_o) begin
            recv_total++;
            pending++;
            if (recv_total - returned > `QUANT_SINK_CREDITS) begin
                $display("Error at %0t: output beyond the granted credits", $time);
                errors++;
            end
            if (exp_q.size() == 0) begin
                $display("Error at %0t: output block with none expected", $time);
                errors++;
            end else begin
                exp_head = exp_q.pop_front();
                if (out_blk_o.nz !== exp_head.nz || out_blk_o.level !== exp_head.level) begin
                    $display("Error at %0t: block %0d nz %0b levels %h, expected nz %0b levels %h",
                             $time, recv_total, out_blk_o.nz, out_blk_o.level, exp_head.nz,
                             exp_head.level);
                    errors++;
                end
                if (out_blk_o.recon !== exp_head.recon) begin
                    $display("Error at %0t: block %0d recon %h, expected %h", $time,
                             recv_total, out_blk_o.recon, exp_head.recon);
                    errors++;
                end
            end
        end
        if (!hold_credits && pending > 0 && (!slow_sink || coin_flip())) begin
            out_credit_i = 1'b1;
            pending--;
            returned++;
        end
    end

    initial begin
        quant_pkg::quant_blk_in_t b;
        seed         = 32'h6501e048;
        rst_n        = 1'b0;
        cfg_we_i     = 1'b0;
        cfg_i        = '0;
        in_valid_i   = 1'b0;
        in_blk_i     = '0;
        out_credit_i = 1'b0;
        send_credits = `QUANT_IN_DEPTH;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        load_file();
        run_test("file_blocks");

        // One coefficient set under every matrix
        b = random_block();
        for (int m = 0; m < 4; m++) begin
            b.mtx = 2'(m);
            add_block(b, model_block(b));
        end
        run_test("matrix_select");

        hold_credits = 1'b1;
        for (int i = 0; i < 10; i++) begin
            b = random_block();
            add_block(b, model_block(b));
        end
        run_test("backpressure");

        slow_sink = 1'b1;
        for (int i = 0; i < 200; i++) begin
            b = random_block();
            add_block(b, model_block(b));
        end
        run_test("random_stream");

        end_run();
    end

endmodule

//--- quant_top.f
+incdir+rtl
rtl/quant_pkg.sv
rtl/quant_credit_fifo.sv
rtl/quant_param_table.sv
rtl/quant_cmd_decode.sv
rtl/quant_block_exec.sv
rtl/quant_result_pack.sv
rtl/quant_top.sv
verif/quant_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the quantizer testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module quant_tb \
    -f quant_top.f -o quant_sim

sim_out=$(./obj_dir/quant_sim)
echo "$sim_out"
grep -q "All checks passed" <<< "$sim_out"

//--- verif/quant_tests.txt
# M mtx q iq bias zthresh sharpen (all positions), C mtx pos q iq bias zthresh sharpen
# B mtx coef0..coef15 in raster order, E nz level0..level15 in zigzag order, all hex
M 0 4 8000 0 0 0
M 1 8 4000 0 7 0
M 2 1 8000 0 0 0
M 3 2 8000 10000 3 1
C 0 f 8 4000 0 0 0
B 0 0010 0008 fff0 0004 0000 0003 fffc 0020 0040 0001 0000 0000 fff8 0000 0000 0030
E 1 0004 0002 0000 0010 0000 fffc 0001 ffff 0000 fffe 0000 0000 0008 0000 0000 0006
B 1 0010 0008 fff0 0004 0000 0003 fffc 0020 0040 0001 0000 0000 fff8 0000 0000 0030
E 1 0002 0001 0000 0008 0000 fffe 0000 0000 0000 ffff 0000 0000 0004 0000 0000 0006
B 2 4000 c000 8000 7fff 0010 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
E 1 07ff f801 0004 0000 0000 f801 07ff 0000 0000 0000 0000 0000 0000 0000 0000 0000
B 3 0002 0003 fffd 0005 0001 0000 000d fff3 0000 0000 0000 0000 0000 0000 0000 0000
E 1 0000 0001 0000 0000 0000 ffff 0002 0004 0000 0000 0000 0000 fffc 0000 0000 0000
B 1 0005 0005 0005 0005 0005 0005 0005 0005 0005 0005 0005 0005 0005 0005 0005 0005
E 0 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
